//--- uproc_debug_pkg.sv
////////////////////
// Debug front end shared definitions.
// Widths, instruction codes, the device ID, the TAP
// state encoding and the structs between the JTAG blocks.
////////////////////
package uproc_debug_pkg;

    ////////////////////
    // Widths.
    ////////////////////

    // One scan cell per GPIO pad.
    localparam int BSCAN_LEN = 16;
    // Instruction register width.
    localparam int IR_LEN = 4;
    // Device ID register width.
    localparam int IDCODE_LEN = 32;

    typedef logic [IR_LEN-1:0]     ir_t;
    typedef logic [BSCAN_LEN-1:0]  gpio_t;
    typedef logic [IDCODE_LEN-1:0] idcode_t;

    ////////////////////
    // Instructions and ID.
    ////////////////////

    // Device ID, bit 0 set as JTAG requires.
    localparam idcode_t IDCODE_VALUE = 32'h1A5C_0001;

    // Instruction codes, anything else acts as BYPASS.
    localparam ir_t IR_EXTEST = 4'b0000;
    localparam ir_t IR_IDCODE = 4'b0001;
    localparam ir_t IR_SAMPLE = 4'b0010;
    localparam ir_t IR_BYPASS = 4'b1111;

    // Fixed pattern loaded into the IR in Capture-IR.
    localparam ir_t IR_CAPTURE = 4'b0001;

    // The sixteen IEEE 1149.1 TAP states.
    typedef enum logic [3:0] {
        TEST_LOGIC_RESET,
        RUN_TEST_IDLE,
        SELECT_DR_SCAN,
        CAPTURE_DR,
        SHIFT_DR,
        EXIT1_DR,
        PAUSE_DR,
        EXIT2_DR,
        UPDATE_DR,
        SELECT_IR_SCAN,
        CAPTURE_IR,
        SHIFT_IR,
        EXIT1_IR,
        PAUSE_IR,
        EXIT2_IR,
        UPDATE_IR
    } tap_state_t;

    // Active data register between TDI and TDO.
    typedef enum logic [1:0] {
        SEL_BYPASS,
        SEL_IDCODE,
        SEL_BSCAN
    } dr_sel_t;

    // Synchronized JTAG pins, TCK edges as single-cycle pulses.
    typedef struct packed {
        logic tck_rise;
        logic tck_fall;
        logic tdi;
        logic tms;
    } jtag_pins_t;

    // Scan controls from the TAP, strobes already qualified by TCK rise.
    typedef struct packed {
        logic    capture_dr;
        logic    shift_dr;
        logic    update_dr;
        logic    shifting_ir;
        logic    shifting_dr;
        logic    extest;
        dr_sel_t dr_sel;
    } scan_ctrl_t;

endpackage

//--- jtag_synch.sv
////////////////////
// JTAG pin synchronizer.
// Brings TCK, TDI and TMS into the system clock domain
// and turns TCK edges into single-cycle pulses.
////////////////////
`timescale 1ns/10ps

module jtag_synch
    import uproc_debug_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_tck,
    input  logic       i_tdi,
    input  logic       i_tms,
    output jtag_pins_t o_pins
);

    // Pin order in the sync vectors is {tck, tdi, tms}.
    logic [2:0] sync1_q;
    logic [2:0] sync2_q;
    // Old TCK sample and the registered edge pulses.
    logic tck_prev_q;
    logic tck_rise_q;
    logic tck_fall_q;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            sync1_q    <= '0;
            sync2_q    <= '0;
            tck_prev_q <= 1'b0;
            tck_rise_q <= 1'b0;
            tck_fall_q <= 1'b0;
        end else begin
            // Two stages against metastability.
            sync1_q    <= {i_tck, i_tdi, i_tms};
            sync2_q    <= sync1_q;
            // Edge detect against the previous sample.
            tck_prev_q <= sync2_q[2];
            tck_rise_q <= sync2_q[2] & ~tck_prev_q;
            tck_fall_q <= ~sync2_q[2] & tck_prev_q;
        end
    end

    assign o_pins.tck_rise = tck_rise_q;
    assign o_pins.tck_fall = tck_fall_q;
    assign o_pins.tdi      = sync2_q[1];
    assign o_pins.tms      = sync2_q[0];

endmodule

//--- jtag_tap.sv
////////////////////
// JTAG TAP controller.
// Sixteen-state TAP machine, 4-bit instruction register
// and the scan control strobes for the data registers.
////////////////////
`timescale 1ns/10ps

module jtag_tap
    import uproc_debug_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_reset,
    input  jtag_pins_t i_pins,
    output scan_ctrl_t o_ctrl,
    output logic       o_ir_tdo
);

    tap_state_t state_q;
    tap_state_t state_d;
    // Shift stage and active instruction.
    ir_t        ir_shift_q;
    ir_t        ir_q;

    ////////////////////
    // TAP state machine.
    ////////////////////

    // Standard TMS transitions.
    always_comb begin
        state_d = state_q;
        case (state_q)
            TEST_LOGIC_RESET: state_d = i_pins.tms ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
            RUN_TEST_IDLE:    state_d = i_pins.tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
            SELECT_DR_SCAN:   state_d = i_pins.tms ? SELECT_IR_SCAN : CAPTURE_DR;
            CAPTURE_DR:       state_d = i_pins.tms ? EXIT1_DR : SHIFT_DR;
            SHIFT_DR:         state_d = i_pins.tms ? EXIT1_DR : SHIFT_DR;
            EXIT1_DR:         state_d = i_pins.tms ? UPDATE_DR : PAUSE_DR;
            PAUSE_DR:         state_d = i_pins.tms ? EXIT2_DR : PAUSE_DR;
            EXIT2_DR:         state_d = i_pins.tms ? UPDATE_DR : SHIFT_DR;
            UPDATE_DR:        state_d = i_pins.tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
            SELECT_IR_SCAN:   state_d = i_pins.tms ? TEST_LOGIC_RESET : CAPTURE_IR;
            CAPTURE_IR:       state_d = i_pins.tms ? EXIT1_IR : SHIFT_IR;
            SHIFT_IR:         state_d = i_pins.tms ? EXIT1_IR : SHIFT_IR;
            EXIT1_IR:         state_d = i_pins.tms ? UPDATE_IR : PAUSE_IR;
            PAUSE_IR:         state_d = i_pins.tms ? EXIT2_IR : PAUSE_IR;
            EXIT2_IR:         state_d = i_pins.tms ? UPDATE_IR : SHIFT_IR;
            UPDATE_IR:        state_d = i_pins.tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
            default:          state_d = TEST_LOGIC_RESET;
        endcase
    end

    // One step per TCK rise.
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state_q <= TEST_LOGIC_RESET;
        end else if (i_pins.tck_rise) begin
            state_q <= state_d;
        end
    end

    ////////////////////
    // Instruction register.
    ////////////////////

    // Shift stage, LSB goes out first.
    always_ff @(posedge i_clk) begin
        if (i_pins.tck_rise) begin
            if (state_q == CAPTURE_IR) begin
                ir_shift_q <= IR_CAPTURE;
            end else if (state_q == SHIFT_IR) begin
                ir_shift_q <= {i_pins.tdi, ir_shift_q[IR_LEN-1:1]};
            end
        end
    end

    // Test-Logic-Reset forces IDCODE, Update-IR loads the shift stage.
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            ir_q <= IR_IDCODE;
        end else if (state_q == TEST_LOGIC_RESET) begin
            ir_q <= IR_IDCODE;
        end else if (i_pins.tck_rise && (state_q == UPDATE_IR)) begin
            ir_q <= ir_shift_q;
        end
    end

    assign o_ir_tdo = ir_shift_q[0];

    ////////////////////
    // Scan controls.
    ////////////////////

    always_comb begin
        // Strobes for the state current at this TCK rise.
        o_ctrl.capture_dr  = i_pins.tck_rise && (state_q == CAPTURE_DR);
        o_ctrl.shift_dr    = i_pins.tck_rise && (state_q == SHIFT_DR);
        o_ctrl.update_dr   = i_pins.tck_rise && (state_q == UPDATE_DR);
        o_ctrl.shifting_ir = (state_q == SHIFT_IR);
        o_ctrl.shifting_dr = (state_q == SHIFT_DR);
        // Instruction decode, unknown codes fall back to bypass.
        case (ir_q)
            IR_EXTEST: begin
                o_ctrl.dr_sel = SEL_BSCAN;
                o_ctrl.extest = 1'b1;
            end
            IR_SAMPLE: begin
                o_ctrl.dr_sel = SEL_BSCAN;
                o_ctrl.extest = 1'b0;
            end
            IR_IDCODE: begin
                o_ctrl.dr_sel = SEL_IDCODE;
                o_ctrl.extest = 1'b0;
            end
            default: begin
                o_ctrl.dr_sel = SEL_BYPASS;
                o_ctrl.extest = 1'b0;
            end
        endcase
    end

    // At most one DR strobe at a time.
    a_dr_strobe_onehot: assert property (@(posedge i_clk) disable iff (i_reset)
        $onehot0({o_ctrl.capture_dr, o_ctrl.shift_dr, o_ctrl.update_dr}))
        else $error("TAP issued more than one DR strobe");

    // No TCK rise, no state change.
    a_state_hold: assert property (@(posedge i_clk) disable iff (i_reset)
        !i_pins.tck_rise |=> $stable(state_q))
        else $error("TAP state moved without a TCK rise");

endmodule

//--- bscan_cell.sv
////////////////////
// Boundary-scan cell for one GPIO pad.
// Capture/shift flop, update latch and pad-drive mux.
////////////////////
`timescale 1ns/10ps

module bscan_cell
    import uproc_debug_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_reset,
    input  scan_ctrl_t i_ctrl,
    input  logic       i_scan_in,
    input  logic       i_pad_in,
    input  logic       i_core_out,
    output logic       o_scan_out,
    output logic       o_pad_out
);

    logic capsh_q;
    logic upd_q;
    logic sel_bscan;

    // Cell only acts while the boundary register is selected.
    assign sel_bscan = (i_ctrl.dr_sel == SEL_BSCAN);

    // Capture the pad, or take the previous cell's bit.
    always_ff @(posedge i_clk) begin
        if (sel_bscan) begin
            if (i_ctrl.capture_dr) begin
                capsh_q <= i_pad_in;
            end else if (i_ctrl.shift_dr) begin
                capsh_q <= i_scan_in;
            end
        end
    end

    // Update latch, cleared so pads start on the core.
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            upd_q <= 1'b0;
        end else if (i_ctrl.update_dr && sel_bscan) begin
            upd_q <= capsh_q;
        end
    end

    assign o_scan_out = capsh_q;
    // EXTEST hands the pad to the latch.
    assign o_pad_out  = i_ctrl.extest ? upd_q : i_core_out;

    a_update_only: assert property (@(posedge i_clk) disable iff (i_reset)
        !i_ctrl.update_dr |=> $stable(upd_q))
        else $error("Scan update latch changed without update_dr");

endmodule

//--- jtag_data_regs.sv
////////////////////
// JTAG data registers and TDO.
// Bypass and IDCODE shift registers, TDO select, and
// retiming of TDO on the TCK falling edge.
////////////////////
`timescale 1ns/10ps

module jtag_data_regs
    import uproc_debug_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_reset,
    input  jtag_pins_t i_pins,
    input  scan_ctrl_t i_ctrl,
    input  logic       i_ir_tdo,
    input  logic       i_bscan_tdo,
    output logic       o_tdo
);

    logic    bypass_q;
    idcode_t idcode_q;
    logic    dr_bit;
    logic    tdo_q;

    ////////////////////
    // Bypass and IDCODE.
    ////////////////////

    // Single-bit bypass, captures 0.
    always_ff @(posedge i_clk) begin
        if (i_ctrl.dr_sel == SEL_BYPASS) begin
            if (i_ctrl.capture_dr) begin
                bypass_q <= 1'b0;
            end else if (i_ctrl.shift_dr) begin
                bypass_q <= i_pins.tdi;
            end
        end
    end

    // Device ID, shifts right with TDI entering at the top.
    always_ff @(posedge i_clk) begin
        if (i_ctrl.dr_sel == SEL_IDCODE) begin
            if (i_ctrl.capture_dr) begin
                idcode_q <= IDCODE_VALUE;
            end else if (i_ctrl.shift_dr) begin
                idcode_q <= {i_pins.tdi, idcode_q[IDCODE_LEN-1:1]};
            end
        end
    end

    ////////////////////
    // TDO.
    ////////////////////

    // Serial output of the active data register.
    always_comb begin
        case (i_ctrl.dr_sel)
            SEL_IDCODE: dr_bit = idcode_q[0];
            SEL_BSCAN:  dr_bit = i_bscan_tdo;
            default:    dr_bit = bypass_q;
        endcase
    end

    // Changes only on TCK fall, zero outside the shift states.
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            tdo_q <= 1'b0;
        end else if (i_pins.tck_fall) begin
            if (i_ctrl.shifting_ir) begin
                tdo_q <= i_ir_tdo;
            end else if (i_ctrl.shifting_dr) begin
                tdo_q <= dr_bit;
            end else begin
                tdo_q <= 1'b0;
            end
        end
    end

    assign o_tdo = tdo_q;

    a_tdo_on_fall: assert property (@(posedge i_clk) disable iff (i_reset)
        !i_pins.tck_fall |=> $stable(tdo_q))
        else $error("TDO changed away from a TCK fall");

endmodule

//--- uproc_debug.sv
////////////////////
// Debug front end top level.
// JTAG synchronizer, TAP controller, GPIO boundary-scan
// chain and the data-register block with TDO.
////////////////////
`timescale 1ns/10ps

module uproc_debug
    import uproc_debug_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_reset,

    // JTAG port.
    input  logic  i_jtag_tck,
    input  logic  i_jtag_tdi,
    input  logic  i_jtag_tms,
    output logic  o_jtag_tdo,

    // GPIO, core drive, observed pads, pad drive.
    input  gpio_t i_gpio_core,
    input  gpio_t i_gpio_pad,
    output gpio_t o_gpio_pad
);

    ////////////////////
    // Internal wires.
    ////////////////////

    jtag_pins_t           jtag_pins;
    scan_ctrl_t           scan_ctrl;
    logic                 ir_tdo;
    // Link k feeds cell k, link BSCAN_LEN is the chain output.
    logic [BSCAN_LEN:0]   scan_link;

    assign scan_link[0] = jtag_pins.tdi;

    ////////////////////
    // Instances.
    ////////////////////

    jtag_synch u_jtag_synch (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_tck   (i_jtag_tck),
        .i_tdi   (i_jtag_tdi),
        .i_tms   (i_jtag_tms),
        .o_pins  (jtag_pins)
    );

    jtag_tap u_jtag_tap (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_pins   (jtag_pins),
        .o_ctrl   (scan_ctrl),
        .o_ir_tdo (ir_tdo)
    );

    // Boundary-scan chain, cell 0 nearest TDI sits on the top pad.
    // So pad 0 is next to TDO and is shifted out first.
    genvar k;
    generate
        for (k = 0; k < BSCAN_LEN; k++) begin : g_bscan
            bscan_cell u_bscan_cell (
                .i_clk      (i_clk),
                .i_reset    (i_reset),
                .i_ctrl     (scan_ctrl),
                .i_scan_in  (scan_link[k]),
                .i_pad_in   (i_gpio_pad[BSCAN_LEN-1-k]),
                .i_core_out (i_gpio_core[BSCAN_LEN-1-k]),
                .o_scan_out (scan_link[k+1]),
                .o_pad_out  (o_gpio_pad[BSCAN_LEN-1-k])
            );
        end
    endgenerate

    jtag_data_regs u_jtag_data_regs (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_pins      (jtag_pins),
        .i_ctrl      (scan_ctrl),
        .i_ir_tdo    (ir_tdo),
        .i_bscan_tdo (scan_link[BSCAN_LEN]),
        .o_tdo       (o_jtag_tdo)
    );

endmodule

//--- uproc_debug_tb.sv
////////////////////
// Debug front end testbench.
// Bit-banged JTAG host that runs IDCODE, BYPASS, SAMPLE
// and EXTEST scans against the GPIO boundary chain.
////////////////////
`timescale 1ns/10ps

module uproc_debug_tb
    import uproc_debug_pkg::*;
();

    localparam logic [31:0] SEED = 32'hf72341d1;
    // System clocks per TCK half period.
    localparam int HALF_CLKS = 8;
    localparam int RESET_TIMEOUT = 50;

    logic  i_clk;
    logic  i_reset;
    logic  i_jtag_tck;
    logic  i_jtag_tdi;
    logic  i_jtag_tms;
    logic  o_jtag_tdo;
    gpio_t i_gpio_core;
    gpio_t i_gpio_pad;
    gpio_t o_gpio_pad;

    int    error_count;
    // Set while the pads must track the core drive.
    logic  watch_core;
    // Pattern left in the update latches by the EXTEST test.
    gpio_t latched_pads;

    uproc_debug i_dut (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_jtag_tck  (i_jtag_tck),
        .i_jtag_tdi  (i_jtag_tdi),
        .i_jtag_tms  (i_jtag_tms),
        .o_jtag_tdo  (o_jtag_tdo),
        .i_gpio_core (i_gpio_core),
        .i_gpio_pad  (i_gpio_pad),
        .o_gpio_pad  (o_gpio_pad)
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    // Reset held for four clocks.
    initial begin
        i_reset <= 1'b1;
        repeat (4) @(posedge i_clk);
        i_reset <= 1'b0;
    end

    ////////////////////
    // Helpers.
    ////////////////////

    function automatic gpio_t random_gpio();
        logic [31:0] r;
        r = $urandom();
        return r[BSCAN_LEN-1:0];
    endfunction

    // Wait whole clocks, checking the pads against the core when asked.
    task automatic pace(input int n);
        repeat (n) begin
            @(negedge i_clk);
            if (watch_core && (o_gpio_pad != i_gpio_core)) begin
                $display("Fail o_gpio_pad 0x%h, expected core 0x%h", o_gpio_pad, i_gpio_core);
                error_count++;
            end
            @(posedge i_clk);
        end
    endtask

    // One TCK cycle, TDO taken just before the rising edge.
    task automatic jtag_clock(input logic tms, input logic tdi, output logic tdo);
        @(posedge i_clk);
        i_jtag_tck <= 1'b0;
        i_jtag_tms <= tms;
        i_jtag_tdi <= tdi;
        pace(HALF_CLKS - 1);
        @(negedge i_clk);
        tdo = o_jtag_tdo;
        @(posedge i_clk);
        i_jtag_tck <= 1'b1;
        pace(HALF_CLKS - 1);
    endtask

    // Five TMS highs reach Test-Logic-Reset from anywhere.
    task automatic jtag_reset();
        logic tdo_drop;
        repeat (5) jtag_clock(1'b1, 1'b0, tdo_drop);
        // Park in Run-Test/Idle.
        jtag_clock(1'b0, 1'b0, tdo_drop);
    endtask

    // Idle to Shift-IR, shift LSB first, update, back to Idle.
    task automatic shift_ir(input ir_t ir_in, output ir_t ir_out);
        logic tdo;
        jtag_clock(1'b1, 1'b0, tdo);
        jtag_clock(1'b1, 1'b0, tdo);
        jtag_clock(1'b0, 1'b0, tdo);
        jtag_clock(1'b0, 1'b0, tdo);
        for (int i = 0; i < IR_LEN; i++) begin
            jtag_clock(i == IR_LEN - 1, ir_in[i], tdo);
            ir_out[i] = tdo;
        end
        jtag_clock(1'b1, 1'b0, tdo);
        jtag_clock(1'b0, 1'b0, tdo);
    endtask

    // Idle to Shift-DR, n bits LSB first, update, back to Idle.
    task automatic shift_dr(input int n, input logic [31:0] tdi_bits,
                            output logic [31:0] tdo_bits);
        logic tdo;
        tdo_bits = '0;
        jtag_clock(1'b1, 1'b0, tdo);
        jtag_clock(1'b0, 1'b0, tdo);
        jtag_clock(1'b0, 1'b0, tdo);
        for (int i = 0; i < n; i++) begin
            jtag_clock(i == n - 1, tdi_bits[i], tdo);
            tdo_bits[i] = tdo;
        end
        jtag_clock(1'b1, 1'b0, tdo);
        jtag_clock(1'b0, 1'b0, tdo);
    endtask

    // Timed wait for reset release, then the reset values.
    task automatic wait_reset_release(output logic released);
        int cycles;
        cycles = 0;
        do begin
            @(posedge i_clk);
            cycles++;
        end while (i_reset && (cycles < RESET_TIMEOUT));
        released = !i_reset;
        @(negedge i_clk);
        if (o_jtag_tdo != 1'b0) begin
            $display("Fail o_jtag_tdo 0x%h after reset, expected 0x0", o_jtag_tdo);
            error_count++;
        end
        if (o_gpio_pad != i_gpio_core) begin
            $display("Fail o_gpio_pad 0x%h after reset, expected 0x%h", o_gpio_pad, i_gpio_core);
            error_count++;
        end
    endtask

    ////////////////////
    // Tests.
    ////////////////////

    task automatic test_idcode_after_reset();
        logic [31:0] got;
        logic tdo;
        // Leave Test-Logic-Reset without an IR load.
        jtag_clock(1'b0, 1'b0, tdo);
        shift_dr(32, 32'h0, got);
        if (got != 32'h1A5C_0001) begin
            $display("Fail o_jtag_tdo idcode scan 0x%h, expected 0x1a5c0001", got);
            error_count++;
        end
        // Stop inside Shift-IR, the reset path then passes Update-IR.
        jtag_clock(1'b1, 1'b0, tdo);
        jtag_clock(1'b1, 1'b0, tdo);
        jtag_clock(1'b0, 1'b0, tdo);
        jtag_clock(1'b0, 1'b0, tdo);
        jtag_reset();
        shift_dr(32, 32'h0, got);
        if (got != 32'h1A5C_0001) begin
            $display("Fail o_jtag_tdo idcode scan after jtag_reset 0x%h, expected 0x1a5c0001",
                     got);
            error_count++;
        end
    endtask

    // Bypass gives a one-bit delay with a captured 0 in front.
    task automatic check_bypass(input ir_t code);
        ir_t ir_got;
        logic [31:0] pattern;
        logic [31:0] got;
        shift_ir(code, ir_got);
        if (ir_got != 4'b0001) begin
            $display("Fail o_jtag_tdo ir capture 0x%h, expected 0x1", ir_got);
            error_count++;
        end
        pattern = {16'h0, random_gpio()};
        shift_dr(16, pattern, got);
        if (got[15:0] != {pattern[14:0], 1'b0}) begin
            $display("Fail o_jtag_tdo bypass scan 0x%h, expected 0x%h for ir 0x%h",
                     got[15:0], {pattern[14:0], 1'b0}, code);
            error_count++;
        end
    endtask

    task automatic test_sample();
        ir_t ir_got;
        gpio_t pads;
        gpio_t core;
        logic [31:0] got;
        shift_ir(4'b0010, ir_got);
        pads = random_gpio();
        core = random_gpio();
        @(posedge i_clk);
        i_gpio_pad  <= pads;
        i_gpio_core <= core;
        watch_core = 1'b1;
        shift_dr(16, 32'h0, got);
        watch_core = 1'b0;
        // Pad values come out LSB first.
        if (got[15:0] != pads) begin
            $display("Fail o_jtag_tdo sample scan 0x%h, expected 0x%h", got[15:0], pads);
            error_count++;
        end
    endtask

    task automatic test_extest();
        ir_t ir_got;
        logic [31:0] pattern;
        logic [31:0] got;
        shift_ir(4'b0000, ir_got);
        pattern = {16'h0, random_gpio()};
        shift_dr(16, pattern, got);
        // Bit i of the shifted pattern drives pad i.
        latched_pads = pattern[15:0];
        @(negedge i_clk);
        if (o_gpio_pad != latched_pads) begin
            $display("Fail o_gpio_pad 0x%h in extest, expected 0x%h", o_gpio_pad, latched_pads);
            error_count++;
        end
        @(posedge i_clk);
        i_gpio_core <= ~i_gpio_core;
        pace(4);
        @(negedge i_clk);
        if (o_gpio_pad != latched_pads) begin
            $display("Fail o_gpio_pad 0x%h after core change, expected 0x%h",
                     o_gpio_pad, latched_pads);
            error_count++;
        end
    endtask

    task automatic test_return_to_core();
        ir_t ir_got;
        shift_ir(4'b0010, ir_got);
        @(negedge i_clk);
        if (o_gpio_pad != i_gpio_core) begin
            $display("Fail o_gpio_pad 0x%h after sample, expected 0x%h", o_gpio_pad, i_gpio_core);
            error_count++;
        end
        // Latches kept their value, so EXTEST shows it again.
        shift_ir(4'b0000, ir_got);
        @(negedge i_clk);
        if (o_gpio_pad != latched_pads) begin
            $display("Fail o_gpio_pad 0x%h on extest reload, expected 0x%h",
                     o_gpio_pad, latched_pads);
            error_count++;
        end
        @(posedge i_clk);
        i_gpio_core <= random_gpio();
        jtag_reset();
        @(negedge i_clk);
        if (o_gpio_pad != i_gpio_core) begin
            $display("Fail o_gpio_pad 0x%h after jtag_reset, expected 0x%h",
                     o_gpio_pad, i_gpio_core);
            error_count++;
        end
    endtask

    ////////////////////
    // Main sequence.
    ////////////////////

    initial begin
        logic released;
        void'($urandom(SEED));
        error_count = 0;
        watch_core = 1'b0;
        latched_pads = '0;
        i_jtag_tck <= 1'b0;
        i_jtag_tdi <= 1'b0;
        i_jtag_tms <= 1'b0;
        i_gpio_core <= random_gpio();
        i_gpio_pad <= '0;
        wait_reset_release(released);
        if (!released) begin
            $display("Timeout, reset was never released");
            $display("tests failed");
        end else begin
            test_idcode_after_reset();
            check_bypass(4'b1111);
            test_sample();
            test_extest();
            test_return_to_core();
            // Unused code 0101 must act as BYPASS.
            check_bypass(4'b0101);
            $display("Checks done, errors: %0d", error_count);
            if (error_count == 0) begin
                $display("all tests passed");
            end else begin
                $display("tests failed");
            end
        end
        $finish;
    end

endmodule

//--- uproc_debug.f
uproc_debug_pkg.sv
jtag_synch.sv
jtag_tap.sv
bscan_cell.sv
jtag_data_regs.sv
uproc_debug.sv
uproc_debug_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the debug front end simulation with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module uproc_debug_tb -f uproc_debug.f \
    --Mdir "$BUILD_DIR" -o uproc_debug_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/uproc_debug_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "tests failed" "$LOG"; then
    echo "Simulation reported failures"
    exit 1
fi

echo "Simulation finished without failures"
exit 0
